/* data_memory.f */
source/dmem_pkg.sv
source/dmem_access_ctrl.sv
source/dmem_bank.sv
source/dmem_load_align.sv
source/data_memory.sv
testbench/data_memory_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data memory testbench, exit status follows the simulation
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --top-module data_memory_tb \
  -f data_memory.f --Mdir obj_dir -o data_memory_sim && \
./obj_dir/data_memory_sim || exit 1

/* source/data_memory.sv */
`timescale 1ns/1ns

module data_memory import dmem_pkg::*; #(
  parameter int num_banks  = 4,
  parameter int bank_depth = 8
) (
  input  logic      clk,
  input  logic      reset,
  input  addr_t     address,
  input  word_t     data_write,
  input  logic      write_en,
  input  logic      read_en,
  input  mem_size_t mem_size,
  input  logic      load_unsigned,
  output word_t     data_out,
  output logic      ready,
  output logic      error
);

  localparam int sel_w = $clog2(num_banks);
  localparam int idx_w = $clog2(bank_depth);

  // controller to banks
  byte_en_t [num_banks-1:0] bank_byte_en;
  logic [idx_w-1:0]         bank_index;
  word_t                    bank_wdata;

  // banks to aligner
  word_t [num_banks-1:0]    bank_rdata;

  // controller to aligner
  logic [sel_w-1:0]         bank_sel;
  logic [1:0]               byte_offset;
  logic                     access_ok;

  dmem_access_ctrl #(
    .num_banks  (num_banks),
    .bank_depth (bank_depth)
  ) u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .address      (address),
    .data_write   (data_write),
    .write_en     (write_en),
    .read_en      (read_en),
    .mem_size     (mem_size),
    .bank_byte_en (bank_byte_en),
    .bank_index   (bank_index),
    .bank_wdata   (bank_wdata),
    .bank_sel     (bank_sel),
    .byte_offset  (byte_offset),
    .access_ok    (access_ok),
    .ready        (ready),
    .error        (error)
  );

  // word-interleaved banks, all at the shared index
  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    dmem_bank #(
      .bank_depth (bank_depth)
    ) u_bank (
      .clk     (clk),
      .byte_en (bank_byte_en[b]),
      .index   (bank_index),
      .wdata   (bank_wdata),
      .rdata   (bank_rdata[b])
    );
  end

  dmem_load_align #(
    .num_banks (num_banks)
  ) u_align (
    .bank_rdata    (bank_rdata),
    .bank_sel      (bank_sel),
    .byte_offset   (byte_offset),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .access_ok     (access_ok),
    .read_en       (read_en),
    .data_out      (data_out)
  );

endmodule

/* source/dmem_access_ctrl.sv */
`timescale 1ns/1ns

module dmem_access_ctrl import dmem_pkg::*; #(
  parameter int num_banks  = 4,
  parameter int bank_depth = 8
) (
  input  logic                               clk,
  input  logic                               reset,
  input  addr_t                              address,
  input  word_t                              data_write,
  input  logic                               write_en,
  input  logic                               read_en,
  input  mem_size_t                          mem_size,
  output byte_en_t [num_banks-1:0]           bank_byte_en,
  output logic [$clog2(bank_depth)-1:0]      bank_index,
  output word_t                              bank_wdata,
  output logic [$clog2(num_banks)-1:0]       bank_sel,
  output logic [1:0]                         byte_offset,
  output logic                               access_ok,
  output logic                               ready,
  output logic                               error
);

  localparam int sel_w = $clog2(num_banks);
  localparam int idx_w = $clog2(bank_depth);

  clear_state_t           state;
  logic [idx_w-1:0]       sweep_cnt;
  logic                   sweeping;
  logic                   misaligned;
  logic                   out_of_range;
  logic [idx_w-1:0]       addr_index;
  logic [29:0]            word_num;
  byte_en_t               lane_en;
  word_t                  lane_data;
  logic [num_banks-1:0]   bank_active;

  // clear sweep zeroes one word per bank per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= clr_sweep;
      sweep_cnt <= '0;
    end else if (state == clr_sweep) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      // last index written on this edge
      if (sweep_cnt == idx_w'(bank_depth - 1)) begin
        state <= clr_ready;
      end
    end
  end

  assign sweeping = (state == clr_sweep);
  assign ready    = (state == clr_ready);

  // address split into offset, bank and index
  assign byte_offset = address[1:0];
  assign bank_sel    = address[2 +: sel_w];
  assign addr_index  = address[2 + sel_w +: idx_w];
  assign word_num    = address[31:2];

  assign out_of_range = (word_num >= 30'(num_banks * bank_depth));

  // halfword needs an even address and word needs low bits zero
  always_comb begin
    case (mem_size)
      size_half: misaligned = address[0];
      size_word: misaligned = (address[1:0] != 2'b00);
      default:   misaligned = 1'b0;
    endcase
  end

  assign access_ok = ready && !misaligned && !out_of_range;
  // accesses before ready are dropped silently
  assign error     = (read_en || write_en) && ready && (misaligned || out_of_range);

  // lane enables and replicated store data
  always_comb begin
    case (mem_size)
      size_byte: begin
        lane_en   = byte_en_t'(4'b0001 << byte_offset);
        lane_data = {4{data_write[7:0]}};
      end
      size_half: begin
        lane_en   = byte_en_t'(4'b0011 << byte_offset);
        lane_data = {2{data_write[15:0]}};
      end
      size_word: begin
        lane_en   = 4'b1111;
        lane_data = data_write;
      end
      default: begin
        lane_en   = 4'b0000;
        lane_data = data_write;
      end
    endcase
  end

  // every bank during the sweep and only the addressed bank after it
  always_comb begin
    for (int b = 0; b < num_banks; b++) begin
      if (sweeping) begin
        bank_byte_en[b] = 4'b1111;
      end else if (write_en && access_ok && (bank_sel == sel_w'(b))) begin
        bank_byte_en[b] = lane_en;
      end else begin
        bank_byte_en[b] = 4'b0000;
      end
      bank_active[b] = |bank_byte_en[b];
    end
  end

  assign bank_index = sweeping ? sweep_cnt : addr_index;
  assign bank_wdata = sweeping ? '0 : lane_data;

  // at most one bank written per access and all of them during the sweep
  a_bank_en_onehot: assert property (@(posedge clk) disable iff (reset)
    sweeping ? (bank_byte_en == '1) : $onehot0(bank_active));

  // no error reported before the sweep is done
  a_no_error_before_ready: assert property (@(posedge clk)
    !ready |-> !error);

endmodule

/* source/dmem_bank.sv */
`timescale 1ns/1ns

module dmem_bank import dmem_pkg::*; #(
  parameter int bank_depth = 8
) (
  input  logic                          clk,
  input  byte_en_t                      byte_en,
  input  logic [$clog2(bank_depth)-1:0] index,
  input  word_t                         wdata,
  output word_t                         rdata
);

  // word storage, zeroed by the controller's sweep
  word_t mem [bank_depth];

  // per-lane write at the rising edge
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (byte_en[lane]) begin
        mem[index][8*lane +: 8] <= wdata[8*lane +: 8];
      end
    end
  end

  // combinational read, same index as the write
  assign rdata = mem[index];

  // writes must land inside the bank
  a_index_in_range: assert property (@(posedge clk)
    (|byte_en) |-> (int'(index) < bank_depth));

endmodule

/* source/dmem_load_align.sv */
`timescale 1ns/1ns

module dmem_load_align import dmem_pkg::*; #(
  parameter int num_banks = 4
) (
  input  word_t [num_banks-1:0]          bank_rdata,
  input  logic [$clog2(num_banks)-1:0]   bank_sel,
  input  logic [1:0]                     byte_offset,
  input  mem_size_t                      mem_size,
  input  logic                           load_unsigned,
  input  logic                           access_ok,
  input  logic                           read_en,
  output word_t                          data_out
);

  word_t sel_word;
  word_t shifted;
  word_t extended;

  // word from the addressed bank
  assign sel_word = bank_rdata[bank_sel];

  // addressed byte or halfword down to bit 0
  assign shifted = sel_word >> {byte_offset, 3'b000};

  // sign or zero extension, word loads pass through
  always_comb begin
    case (mem_size)
      size_byte: begin
        if (load_unsigned) begin
          extended = {24'b0, shifted[7:0]};
        end else begin
          extended = {{24{shifted[7]}}, shifted[7:0]};
        end
      end
      size_half: begin
        if (load_unsigned) begin
          extended = {16'b0, shifted[15:0]};
        end else begin
          extended = {{16{shifted[15]}}, shifted[15:0]};
        end
      end
      size_word: extended = sel_word;
      default:   extended = '0;
    endcase
  end

  // zero when idle, not ready or illegal
  assign data_out = (read_en && access_ok) ? extended : '0;

endmodule

/* source/dmem_pkg.sv */
package dmem_pkg;

  // byte address from the load/store unit
  typedef logic [31:0] addr_t;

  // one memory word
  typedef logic [31:0] word_t;

  // one enable per byte lane of a word
  typedef logic [3:0] byte_en_t;

  // access width of a load or store
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_t;

  // clear sweep after reset, then normal operation
  typedef enum logic {
    clr_sweep = 1'b0,
    clr_ready = 1'b1
  } clear_state_t;

endpackage

/* testbench/data_memory_tb.sv */
`timescale 1ns/1ns

module data_memory_tb
  import dmem_pkg::*;
();

  localparam int num_banks  = 4;
  localparam int bank_depth = 8;
  localparam int num_words  = num_banks * bank_depth;
  localparam int num_random = 40;

  // row operations
  localparam logic [1:0] op_idle  = 2'd0;
  localparam logic [1:0] op_write = 2'd1;
  localparam logic [1:0] op_read  = 2'd2;

  // one directed access and its expected response
  typedef struct packed {
    logic [1:0] op;
    mem_size_t  size;
    logic       uns;
    addr_t      addr;
    word_t      wdata;
    word_t      exp_data;
    logic       exp_err;
  } row_t;

  logic      clk;
  logic      reset;
  addr_t     address;
  word_t     data_write;
  logic      write_en;
  logic      read_en;
  mem_size_t mem_size;
  logic      load_unsigned;
  word_t     data_out;
  logic      ready;
  logic      error;

  row_t   rows [$];
  word_t  shadow [num_words];
  integer seed;
  int     cycle_cnt = 0;
  int     timeout_limit;

  data_memory #(
    .num_banks  (num_banks),
    .bank_depth (bank_depth)
  ) uut (
    .clk           (clk),
    .reset         (reset),
    .address       (address),
    .data_write    (data_write),
    .write_en      (write_en),
    .read_en       (read_en),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .data_out      (data_out),
    .ready         (ready),
    .error         (error)
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout, run still going after %0d cycles", timeout_limit);
    end
  end

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("error: time %0t ns, %s = %h, expected %h", $time, name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // store merged into a word with lanes from size and offset
  function automatic word_t merge_store(input word_t old, input mem_size_t size,
                                        input logic [1:0] offset, input word_t data);
    word_t      result;
    logic [4:0] lane_lsb;
    result   = old;
    lane_lsb = {offset, 3'b000};
    case (size)
      size_byte: result[lane_lsb +: 8] = data[7:0];
      size_half: result[lane_lsb +: 16] = data[15:0];
      default:   result = data;
    endcase
    return result;
  endfunction

  task automatic add_row(input logic [1:0] op, input mem_size_t size, input logic uns,
                         input addr_t addr, input word_t wdata, input word_t exp_data,
                         input logic exp_err);
    row_t row;
    row = '{op, size, uns, addr, wdata, exp_data, exp_err};
    rows.push_back(row);
  endtask

  // drive one access on the rising edge and check it mid-cycle
  task automatic run_access(input logic [1:0] op, input mem_size_t size, input logic uns,
                            input addr_t addr, input word_t wdata, input word_t exp_data,
                            input logic exp_err);
    @(posedge clk);
    write_en      <= (op == op_write);
    read_en       <= (op == op_read);
    mem_size      <= size;
    load_unsigned <= uns;
    address       <= addr;
    data_write    <= wdata;
    @(negedge clk);
    check_value("error", 32'(error), 32'(exp_err));
    // write rows check error only
    if (op != op_write) begin
      check_value("data_out", data_out, exp_data);
    end
    // legal store lands in the shadow copy
    if (op == op_write && !exp_err) begin
      shadow[addr[6:2]] = merge_store(shadow[addr[6:2]], size, addr[1:0], wdata);
    end
  endtask

  initial begin
    word_t r;
    word_t wr_data;
    addr_t wr_addr;
    addr_t rd_addr;

    reset         = 1'b1;
    address       = 32'h0000_0002;
    data_write    = 32'h0;
    write_en      = 1'b0;
    // misaligned read held through reset stays silent
    read_en       = 1'b1;
    mem_size      = size_word;
    load_unsigned = 1'b0;
    seed          = 32'hb3b1_6a4b;
    foreach (shadow[i]) shadow[i] = 32'h0;

    // word writes in all four banks and their read back
    add_row(op_write, size_word, 1'b0, 32'h00, 32'h1234_5678, 32'h0, 1'b0);
    add_row(op_write, size_word, 1'b0, 32'h04, 32'hdead_beef, 32'h0, 1'b0);
    add_row(op_write, size_word, 1'b0, 32'h08, 32'hcafe_f00d, 32'h0, 1'b0);
    add_row(op_write, size_word, 1'b0, 32'h0c, 32'h0bad_c0de, 32'h0, 1'b0);
    add_row(op_write, size_word, 1'b0, 32'h7c, 32'ha5a5_5a5a, 32'h0, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h00, 32'h0, 32'h1234_5678, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h04, 32'h0, 32'hdead_beef, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h08, 32'h0, 32'hcafe_f00d, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h0c, 32'h0, 32'h0bad_c0de, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h7c, 32'h0, 32'ha5a5_5a5a, 1'b0);
    add_row(op_idle,  size_word, 1'b0, 32'h04, 32'h0, 32'h0, 1'b0);
    // partial stores merged into a known pattern
    add_row(op_write, size_word, 1'b0, 32'h10, 32'h1122_3344, 32'h0, 1'b0);
    add_row(op_write, size_byte, 1'b0, 32'h11, 32'hffff_ffab, 32'h0, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h10, 32'h0, 32'h1122_ab44, 1'b0);
    add_row(op_write, size_half, 1'b0, 32'h12, 32'h0000_beef, 32'h0, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h10, 32'h0, 32'hbeef_ab44, 1'b0);
    add_row(op_write, size_byte, 1'b0, 32'h13, 32'h0000_0077, 32'h0, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h10, 32'h0, 32'h77ef_ab44, 1'b0);
    add_row(op_write, size_word, 1'b0, 32'h14, 32'h0000_0000, 32'h0, 1'b0);
    add_row(op_write, size_half, 1'b0, 32'h14, 32'hffff_1234, 32'h0, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h14, 32'h0, 32'h0000_1234, 1'b0);
    // every byte and halfword has its top bit set
    add_row(op_write, size_word, 1'b0, 32'h18, 32'hf182_a394, 32'h0, 1'b0);
    add_row(op_read,  size_byte, 1'b0, 32'h18, 32'h0, 32'hffff_ff94, 1'b0);
    add_row(op_read,  size_byte, 1'b1, 32'h18, 32'h0, 32'h0000_0094, 1'b0);
    add_row(op_read,  size_byte, 1'b0, 32'h19, 32'h0, 32'hffff_ffa3, 1'b0);
    add_row(op_read,  size_byte, 1'b1, 32'h19, 32'h0, 32'h0000_00a3, 1'b0);
    add_row(op_read,  size_byte, 1'b0, 32'h1a, 32'h0, 32'hffff_ff82, 1'b0);
    add_row(op_read,  size_byte, 1'b1, 32'h1a, 32'h0, 32'h0000_0082, 1'b0);
    add_row(op_read,  size_byte, 1'b0, 32'h1b, 32'h0, 32'hffff_fff1, 1'b0);
    add_row(op_read,  size_byte, 1'b1, 32'h1b, 32'h0, 32'h0000_00f1, 1'b0);
    add_row(op_read,  size_half, 1'b0, 32'h18, 32'h0, 32'hffff_a394, 1'b0);
    add_row(op_read,  size_half, 1'b1, 32'h18, 32'h0, 32'h0000_a394, 1'b0);
    add_row(op_read,  size_half, 1'b0, 32'h1a, 32'h0, 32'hffff_f182, 1'b0);
    add_row(op_read,  size_half, 1'b1, 32'h1a, 32'h0, 32'h0000_f182, 1'b0);
    add_row(op_read,  size_byte, 1'b0, 32'h13, 32'h0, 32'h0000_0077, 1'b0);
    // word load ignores the unsigned flag
    add_row(op_read,  size_word, 1'b1, 32'h18, 32'h0, 32'hf182_a394, 1'b0);
    // misaligned and out of range
    add_row(op_read,  size_half, 1'b0, 32'h19, 32'h0, 32'h0, 1'b1);
    add_row(op_read,  size_word, 1'b0, 32'h1a, 32'h0, 32'h0, 1'b1);
    add_row(op_read,  size_word, 1'b0, 32'h19, 32'h0, 32'h0, 1'b1);
    add_row(op_write, size_word, 1'b0, 32'h1a, 32'hffff_ffff, 32'h0, 1'b1);
    add_row(op_write, size_half, 1'b0, 32'h1b, 32'h0000_ffff, 32'h0, 1'b1);
    add_row(op_read,  size_word, 1'b0, 32'h18, 32'h0, 32'hf182_a394, 1'b0);
    add_row(op_read,  size_word, 1'b0, 32'h80, 32'h0, 32'h0, 1'b1);
    // 0x80 aliases word 0 if the range check fails
    add_row(op_write, size_word, 1'b0, 32'h80, 32'h5555_5555, 32'h0, 1'b1);
    add_row(op_read,  size_word, 1'b0, 32'h00, 32'h0, 32'h1234_5678, 1'b0);
    // 0xfc aliases word 0x7c
    add_row(op_write, size_byte, 1'b0, 32'hfc, 32'h0000_00ff, 32'h0, 1'b1);
    add_row(op_read,  size_word, 1'b0, 32'h7c, 32'h0, 32'ha5a5_5a5a, 1'b0);
    add_row(op_read,  size_byte, 1'b0, 32'h1000_0000, 32'h0, 32'h0, 1'b1);
    // no error without a strobe even when misaligned
    add_row(op_idle,  size_half, 1'b0, 32'h19, 32'h0, 32'h0, 1'b0);

    timeout_limit = 5 + bank_depth + rows.size() + 2 * num_random + 50;

    // reset high for five rising edges
    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      check_value("ready", 32'(ready), 32'd0);
      check_value("error", 32'(error), 32'd0);
    end
    // low for bank_depth cycles after reset drops
    for (int k = 0; k < bank_depth; k++) begin
      @(posedge clk);
      if (k == 0) begin
        reset <= 1'b0;
      end
      // misaligned read alternates with a legal read of the last word to be cleared
      address <= k[0] ? 32'h0000_007c : 32'h0000_0002;
      @(negedge clk);
      check_value("ready", 32'(ready), 32'd0);
      check_value("error", 32'(error), 32'd0);
      check_value("data_out", data_out, 32'h0);
    end
    @(posedge clk);
    @(negedge clk);
    check_value("ready", 32'(ready), 32'd1);

    // sweep left every word zero
    for (int i = 0; i < num_words; i++) begin
      run_access(op_read, size_word, 1'b0, 32'(4 * i), 32'h0, 32'h0, 1'b0);
    end

    foreach (rows[i]) begin
      run_access(rows[i].op, rows[i].size, rows[i].uns, rows[i].addr, rows[i].wdata,
                 rows[i].exp_data, rows[i].exp_err);
    end

    // random word traffic against the shadow copy
    for (int n = 0; n < num_random; n++) begin
      r       = $random(seed);
      wr_addr = {25'b0, r[4:0], 2'b00};
      wr_data = $random(seed);
      run_access(op_write, size_word, 1'b0, wr_addr, wr_data, 32'h0, 1'b0);
      r       = $random(seed);
      rd_addr = {25'b0, r[4:0], 2'b00};
      run_access(op_read, size_word, 1'b0, rd_addr, 32'h0, shadow[r[4:0]], 1'b0);
    end

    run_access(op_idle, size_word, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
